/* bench/hdr_vectors.hex */
# columns: random code addr len d0 d1 d2 d3 d4 d5 d6 d7 crc5
# random 1 replaces the data words and the crc with generated values
0 1b 52 1 0000 0000 0000 0000 0000 0000 0000 0000 01
0 20 08 1 ffff 0000 0000 0000 0000 0000 0000 0000 0a
0 7f 7f 2 0000 ffff 0000 0000 0000 0000 0000 0000 10
1 0a 31 8 0000 0000 0000 0000 0000 0000 0000 0000 00
1 44 12 3 0000 0000 0000 0000 0000 0000 0000 0000 00
1 05 7e 5 0000 0000 0000 0000 0000 0000 0000 0000 00
1 33 01 8 0000 0000 0000 0000 0000 0000 0000 0000 00
1 61 40 1 0000 0000 0000 0000 0000 0000 0000 0000 00

/* verilog.f */
rtl/hdr_pkg.sv
rtl/hdr_cfg_if.sv
rtl/hdr_tx_if.sv
rtl/hdr_regfile.sv
rtl/ddr_sequencer.sv
rtl/ddr_frame_tx.sv
rtl/scl_gen.sv
rtl/hdr_ddr_top.sv
bench/hdr_ddr_props.sv
bench/hdr_ddr_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= hdr_ddr_tb
RTL_TOP   ?= hdr_ddr_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) rtl/hdr_pkg.sv rtl/hdr_cfg_if.sv \
		rtl/hdr_tx_if.sv rtl/hdr_regfile.sv rtl/ddr_sequencer.sv rtl/ddr_frame_tx.sv \
		rtl/scl_gen.sv rtl/hdr_ddr_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/hdr_ddr_tb.sv */
module hdr_ddr_tb;
   import hdr_pkg::*;

   localparam int SCL_DIV   = 4;
   localparam int BUF_DEPTH = 8;
   localparam int N_VEC_MAX = 16;
   localparam int LIMIT     = N_VEC_MAX * (31 + 20 * 8) * 2 * SCL_DIV + 3000;

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 wb_cyc, wb_stb, wb_we;
   logic [REG_ADR_W-1:0] wb_adr;
   logic [WORD_W-1:0]    wb_dat, wb_rdat;
   logic                 wb_ack, scl, sda, busy, done;

   int          errors = 0;
   int          cycles = 0;
   int          n_tests = 0;
   int          n_failed = 0;
   bit          bitq[$];     // sda sampled at each scl edge
   logic        scl_prev = 1'b0;
   logic [31:0] lcg_state = 32'd39619;

   hdr_ddr_top #(.SCL_DIV(SCL_DIV), .BUF_DEPTH(BUF_DEPTH)) dut_i (
      .i_sys_clk (clk), .i_rst (rst),
      .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we),
      .i_wb_adr (wb_adr), .i_wb_dat (wb_dat), .o_wb_dat (wb_rdat), .o_wb_ack (wb_ack),
      .o_scl (scl), .o_sda (sda), .o_busy (busy), .o_done (done)
   );

   always #5 clk = ~clk;

   // run limit in clock cycles
   initial begin
      while (cycles < LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, no end of run after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
   end

   // negedge sees scl and sda settled since the last posedge
   always @(negedge clk) begin
      if (!rst && scl != scl_prev)
         bitq.push_back(sda);
      scl_prev = scl;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [19:0] frame_bits(logic [1:0] pre, logic [15:0] w);
      logic p1;
      logic p0;
      p1 = ^(w & 16'hAAAA);   // bits 15, 13 .. 1
      p0 = ~^(w & 16'h5555);  // inverted xor of bits 14, 12 .. 0
      return {pre, w, p1, p0};
   endfunction

   function automatic logic [4:0] crc5_model(logic [15:0] w[8], int len);
      logic [4:0] c;
      logic       fb;
      c = 5'h1F;
      for (int i = 0; i < len; i++) begin
         for (int b = 15; b >= 0; b--) begin
            fb = c[4] ^ w[i][b];
            c  = {c[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
         end
      end
      return c;
   endfunction

   function automatic logic [31:0] get_bits(int pos, int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], logic'(bitq[pos + i])};
      return v;
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic wb_access(input logic we, input logic [3:0] adr, input logic [15:0] wdat,
                            output logic [15:0] rdat);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= we;
      wb_adr <= adr;
      wb_dat <= wdat;
      @(negedge clk);  // request cycle itself
      check_eq("o_wb_ack early", wb_ack, 1'b0);
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < 8);
      check_eq("wb_ack_latency", waited, 1);
      rdat = wb_rdat;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic run_transfer(input logic [6:0] code, input logic [6:0] addr, input int len,
                               input logic [15:0] w[8], input logic [4:0] exp_crc);
      logic [15:0] rd;
      int          nbits;
      wb_access(1'b1, REG_CMD, {1'b0, code, 1'b0, addr}, rd);
      wb_access(1'b1, REG_LEN, 16'(len), rd);
      for (int i = 0; i < len; i++)
         wb_access(1'b1, REG_BUF_BASE + 4'(i), w[i], rd);
      wb_access(1'b0, REG_CMD, 16'h0, rd);
      check_eq("wb_dat REG_CMD", rd, {1'b0, code, 1'b0, addr});
      wb_access(1'b0, REG_LEN, 16'h0, rd);
      check_eq("wb_dat REG_LEN", rd, len);
      for (int i = 0; i < len; i++) begin
         wb_access(1'b0, REG_BUF_BASE + 4'(i), 16'h0, rd);
         check_eq("wb_dat buffer", rd, w[i]);
      end
      bitq.delete();
      wb_access(1'b1, REG_CTRL, 16'h1, rd);
      @(negedge clk);
      check_eq("o_busy after start", busy, 1'b1);
      // with len 0 in REG_LEN an accepted start would flag a length error
      wb_access(1'b1, REG_LEN, 16'h0, rd);
      wb_access(1'b1, REG_CTRL, 16'h1, rd);  // must be ignored
      while (!done)
         @(negedge clk);
      check_eq("o_busy at done", busy, 1'b0);
      repeat (40 * SCL_DIV) begin
         @(negedge clk);
         check_eq("o_done extra pulse", done, 1'b0);
      end
      check_eq("o_busy after done", busy, 1'b0);
      check_eq("o_scl idle", scl, 1'b0);
      check_eq("o_sda idle", sda, 1'b1);
      // one idle edge after the odd crc frame brings scl back low
      nbits = 20 * (len + 1) + 11;
      check_eq("scl edge count", bitq.size(), nbits + 1);
      if (bitq.size() == nbits + 1) begin
         check_eq("cmd frame", get_bits(0, 20), frame_bits(2'b01, {1'b0, code, addr, 1'b0}));
         for (int i = 0; i < len; i++)
            check_eq("data frame", get_bits(20 * (i + 1), 20), frame_bits(2'b10, w[i]));
         check_eq("crc frame", get_bits(20 * (len + 1), 11), {2'b01, 4'hC, exp_crc});
         check_eq("sda return edge", get_bits(nbits, 1), 1);
      end
      wb_access(1'b0, REG_STATUS, 16'h0, rd);
      check_eq("wb_dat REG_STATUS", rd, 16'h0002);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      n_tests++;
      if (errors == errs_before) begin
         $display("test %0d %s ok", n_tests, name);
      end else begin
         n_failed++;
         $display("test %0d %s failed", n_tests, name);
      end
   endtask

   initial begin
      int          fd, r, e0, rnd, len;
      string       line;
      logic [15:0] w[8];
      logic [6:0]  code, addr;
      logic [4:0]  crc;
      logic [15:0] rd;
      rst    = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      wb_adr = '0;
      wb_dat = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      fd = $fopen("bench/hdr_vectors.hex", "r");
      if (fd == 0) begin
         $display("cannot open the vector file");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 1 && line[0] != "#") begin
               r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", rnd, code, addr,
                           len, w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], crc);
               if (rnd != 0) begin
                  for (int i = 0; i < 8; i++)
                     w[i] = 16'(lcg_next() >> 8);
                  crc = crc5_model(w, len);
               end
               e0 = errors;
               run_transfer(code, addr, len, w, crc);
               finish_test($sformatf("transfer len %0d", len), e0);
            end
         end
         $fclose(fd);
      end
      // zero length start is refused
      e0 = errors;
      bitq.delete();
      wb_access(1'b1, REG_LEN, 16'h0, rd);
      wb_access(1'b1, REG_CTRL, 16'h1, rd);
      wb_access(1'b0, REG_STATUS, 16'h0, rd);
      check_eq("wb_dat REG_STATUS", rd, 16'h0004);
      repeat (20 * SCL_DIV) @(negedge clk);
      check_eq("scl edges after len 0", bitq.size(), 0);
      check_eq("o_busy after len 0", busy, 1'b0);
      finish_test("len 0 guard", e0);
      $display("%0d tests, %0d failed, %0d failed checks", n_tests, n_failed, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* bench/hdr_ddr_props.sv */
module hdr_ddr_props (
   input logic        i_clk,
   input logic        i_rst,
   input logic        i_ack,
   input logic        i_valid,
   input logic        i_ready,
   input logic [15:0] i_word,
   input logic        i_busy,
   input logic        i_done,
   input logic        i_scl,
   input logic        i_sda
);

   // wishbone ack is a single clock
   ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ack |=> !i_ack)
      else $error("wishbone ack held longer than one cycle");

   // back-pressure, payload frozen until the serializer takes it
   word_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_valid && !i_ready) |=> (i_word == $past(i_word)))
      else $error("tx word moved while waiting for ready");

   done_with_busy_fall: assert property (@(posedge i_clk) disable iff (i_rst)
      i_done |-> (!i_busy && $past(i_busy)))
      else $error("done pulse not aligned with busy falling");

   sda_stable_on_scl: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_scl != $past(i_scl)) |-> (i_sda == $past(i_sda)))
      else $error("sda changed together with an scl edge");

endmodule

bind hdr_ddr_top hdr_ddr_props props_i (
   .i_clk   (i_sys_clk),
   .i_rst   (i_rst),
   .i_ack   (o_wb_ack),
   .i_valid (tx_if.valid),
   .i_ready (tx_if.ready),
   .i_word  (tx_if.word),
   .i_busy  (o_busy),
   .i_done  (o_done),
   .i_scl   (o_scl),
   .i_sda   (o_sda)
);

/* rtl/hdr_ddr_top.sv */
module hdr_ddr_top #(
   parameter int SCL_DIV   = 4,
   parameter int BUF_DEPTH = 8
) (
   input  logic                          i_sys_clk,
   input  logic                          i_rst,
   // wishbone classic slave
   input  logic                          i_wb_cyc,
   input  logic                          i_wb_stb,
   input  logic                          i_wb_we,
   input  logic [hdr_pkg::REG_ADR_W-1:0] i_wb_adr,
   input  logic [hdr_pkg::WORD_W-1:0]    i_wb_dat,
   output logic [hdr_pkg::WORD_W-1:0]    o_wb_dat,
   output logic                          o_wb_ack,
   // i3c bus, push-pull
   output logic                          o_scl,
   output logic                          o_sda,
   output logic                          o_busy,
   output logic                          o_done
);

   logic scl_run;
   logic scl_toggle;
   logic sda_change;

   hdr_cfg_if cfg_if ();
   hdr_tx_if  tx_if ();

   hdr_regfile #(
      .BUF_DEPTH (BUF_DEPTH)
   ) regfile_i (
      .i_sys_clk (i_sys_clk),
      .i_rst     (i_rst),
      .i_wb_cyc  (i_wb_cyc),
      .i_wb_stb  (i_wb_stb),
      .i_wb_we   (i_wb_we),
      .i_wb_adr  (i_wb_adr),
      .i_wb_dat  (i_wb_dat),
      .o_wb_dat  (o_wb_dat),
      .o_wb_ack  (o_wb_ack),
      .cfg       (cfg_if.regf)
   );

   ddr_sequencer #(
      .BUF_DEPTH (BUF_DEPTH)
   ) sequencer_i (
      .i_sys_clk (i_sys_clk),
      .i_rst     (i_rst),
      .cfg       (cfg_if.seq),
      .tx        (tx_if.seq),
      .o_busy    (o_busy),
      .o_done    (o_done)
   );

   ddr_frame_tx frame_tx_i (
      .i_sys_clk    (i_sys_clk),
      .i_rst        (i_rst),
      .i_scl_toggle (scl_toggle),
      .i_sda_change (sda_change),
      .tx           (tx_if.tx),
      .o_sda        (o_sda),
      .o_scl_run    (scl_run)
   );

   scl_gen #(
      .SCL_DIV (SCL_DIV)
   ) scl_gen_i (
      .i_sys_clk    (i_sys_clk),
      .i_rst        (i_rst),
      .i_run        (scl_run),
      .o_scl        (o_scl),
      .o_scl_toggle (scl_toggle),
      .o_sda_change (sda_change)
   );

endmodule

/* rtl/scl_gen.sv */
module scl_gen #(
   parameter int SCL_DIV = 4  // sys clocks per scl half period, even, >= 4
) (
   input  logic i_sys_clk,
   input  logic i_rst,
   input  logic i_run,
   output logic o_scl,
   output logic o_scl_toggle,
   output logic o_sda_change
);

   localparam int CNT_W = $clog2(SCL_DIV);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_DIV - 1);
   localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(SCL_DIV/2 - 1);

   logic [CNT_W-1:0] cnt_q;

   // sda moves half way through each half period, scl at its end
   assign o_sda_change = i_run && (cnt_q == CNT_MID);
   assign o_scl_toggle = i_run && (cnt_q == CNT_LAST);

   always_ff @(posedge i_sys_clk) begin
      if (i_rst) begin
         cnt_q <= '0;
         o_scl <= 1'b0;
      end else if (!i_run) begin
         cnt_q <= '0;
         o_scl <= 1'b0;  // parked low
      end else if (o_scl_toggle) begin
         cnt_q <= '0;
         o_scl <= ~o_scl;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

endmodule

/* rtl/ddr_frame_tx.sv */
module ddr_frame_tx (
   input  logic  i_sys_clk,
   input  logic  i_rst,
   input  logic  i_scl_toggle,
   input  logic  i_sda_change,
   hdr_tx_if.tx  tx,
   output logic  o_sda,
   output logic  o_scl_run
);
   import hdr_pkg::*;

   localparam int FRAME_W = 2 + WORD_W + 2;  // preamble, payload, parity
   localparam int CRC_W   = 2 + 4 + 5;       // preamble, token, crc5
   localparam logic [4:0] BITS_FULL = 5'(FRAME_W);
   localparam logic [4:0] BITS_CRC  = 5'(CRC_W);
   localparam logic [4:0] PAY_HI    = 5'(FRAME_W - 2);  // bits left when payload msb goes out
   localparam logic [4:0] PAY_LO    = 5'd3;
   localparam logic [4:0] CRC_POLY  = 5'h05;            // x^5 + x^2 + 1
   localparam logic [WORD_W-1:0] ODD_MASK  = {(WORD_W/2){2'b10}};
   localparam logic [WORD_W-1:0] EVEN_MASK = {(WORD_W/2){2'b01}};

   logic [FRAME_W-1:0] shift_q;
   logic [4:0]         bits_q;    // bits still to place on sda
   frame_kind_e        kind_q;
   logic               loaded_q;
   logic               tail_q;    // last bit out, its toggle still pending
   logic               scl_hi_q;  // tracks scl level from the toggles
   logic [4:0]         crc_q;
   logic               take;
   logic               p1;
   logic               p0;
   logic               in_payload;
   logic               crc_fb;

   assign take       = tx.valid & tx.ready;
   assign p1         = ^(tx.word.data & ODD_MASK);
   assign p0         = ~^(tx.word.data & EVEN_MASK);
   assign in_payload = (kind_q == FRAME_DATA) && (bits_q <= PAY_HI) && (bits_q >= PAY_LO);
   assign crc_fb     = crc_q[4] ^ shift_q[FRAME_W-1];

   // keep scl running until it is back low, odd crc frame needs one more edge
   assign o_scl_run = loaded_q | tail_q | scl_hi_q;
   assign tx.ready  = ~o_scl_run;

   always_ff @(posedge i_sys_clk) begin
      if (i_rst) begin
         loaded_q <= 1'b0;
         tail_q   <= 1'b0;
         scl_hi_q <= 1'b0;
         bits_q   <= '0;
         kind_q   <= FRAME_CMD;
         crc_q    <= CRC_INIT;
         o_sda    <= 1'b1;
      end else begin
         if (i_scl_toggle) begin
            scl_hi_q <= ~scl_hi_q;
            tail_q   <= 1'b0;
         end
         // take only happens with scl stopped, so no strobes here
         if (take) begin
            loaded_q <= 1'b1;
            kind_q   <= tx.kind;
            bits_q   <= (tx.kind == FRAME_CRC) ? BITS_CRC : BITS_FULL;
            if (tx.kind == FRAME_CMD)
               crc_q <= CRC_INIT;  // new transfer
         end else if (i_sda_change) begin
            if (loaded_q) begin
               o_sda  <= shift_q[FRAME_W-1];
               bits_q <= bits_q - 5'd1;
               if (in_payload)
                  crc_q <= {crc_q[3:0], 1'b0} ^ (crc_fb ? CRC_POLY : 5'h00);
               if (bits_q == 5'd1) begin
                  loaded_q <= 1'b0;
                  tail_q   <= 1'b1;
               end
            end else begin
               o_sda <= 1'b1;  // idle level while scl returns low
            end
         end
      end
   end

   always_ff @(posedge i_sys_clk) begin
      if (take) begin
         case (tx.kind)
            FRAME_CMD:  shift_q <= {PRE_CMD, tx.word.data, p1, p0};
            FRAME_DATA: shift_q <= {PRE_DATA, tx.word.data, p1, p0};
            default:    shift_q <= {PRE_CRC, CRC_TOKEN, crc_q, {(FRAME_W-CRC_W){1'b0}}};
         endcase
      end else if (i_sda_change && loaded_q) begin
         shift_q <= {shift_q[FRAME_W-2:0], 1'b0};
      end
   end

endmodule

/* rtl/ddr_sequencer.sv */
module ddr_sequencer #(
   parameter int BUF_DEPTH = 8
) (
   input  logic    i_sys_clk,
   input  logic    i_rst,
   hdr_cfg_if.seq  cfg,
   hdr_tx_if.seq   tx,
   output logic    o_busy,
   output logic    o_done
);
   import hdr_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_CMD,
      S_DATA,
      S_CRC,
      S_FINISH
   } state_e;

   localparam logic [IDX_W-1:0] DEPTH_L = IDX_W'(BUF_DEPTH);

   state_e           state_q;
   frame_kind_e      kind_q;
   ddr_payload_u     word_q;
   logic             valid_q;
   logic             done_q;
   logic [IDX_W-1:0] idx_q;  // buffer words fetched so far
   logic [IDX_W-1:0] len_q;
   logic             take;
   logic             last_data;
   logic             busy;

   assign take      = tx.valid & tx.ready;
   assign last_data = (idx_q == len_q) || (idx_q == DEPTH_L);  // never past the buffer
   assign busy      = (state_q != S_IDLE);

   always_ff @(posedge i_sys_clk) begin
      if (i_rst) begin
         state_q <= S_IDLE;
         kind_q  <= FRAME_CMD;
         valid_q <= 1'b0;
         done_q  <= 1'b0;
         idx_q   <= '0;
         len_q   <= '0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (cfg.start) begin
                  state_q <= S_CMD;
                  kind_q  <= FRAME_CMD;
                  valid_q <= 1'b1;
                  idx_q   <= '0;
                  len_q   <= cfg.len;  // host may rewrite LEN mid transfer
               end
            end
            S_CMD: begin
               if (take) begin
                  state_q <= S_DATA;
                  kind_q  <= FRAME_DATA;
                  idx_q   <= idx_q + 1'b1;
               end
            end
            S_DATA: begin
               if (take) begin
                  if (last_data) begin
                     state_q <= S_CRC;
                     kind_q  <= FRAME_CRC;
                  end else begin
                     idx_q <= idx_q + 1'b1;
                  end
               end
            end
            S_CRC: begin
               if (take) begin
                  valid_q <= 1'b0;
                  state_q <= S_FINISH;
               end
            end
            S_FINISH: begin
               // ready returns once the crc frame is out and scl is back low
               if (tx.ready) begin
                  done_q  <= 1'b1;
                  state_q <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // payload only moves on a handshake
   always_ff @(posedge i_sys_clk) begin
      if (state_q == S_IDLE && cfg.start) begin
         word_q.cmd.rnw  <= 1'b0;
         word_q.cmd.code <= cfg.cmd_word[14:8];
         word_q.cmd.addr <= cfg.cmd_word[6:0];
         word_q.cmd.pad  <= 1'b0;
      end else if (take && (state_q == S_CMD || (state_q == S_DATA && !last_data))) begin
         word_q.data <= cfg.buf_word;  // buf_idx already points at the next word
      end
   end

   assign tx.valid    = valid_q;
   assign tx.kind     = kind_q;
   assign tx.word     = word_q;
   assign cfg.buf_idx = idx_q;
   assign cfg.busy    = busy;
   assign cfg.done    = done_q;
   assign cfg.err     = 1'b0;  // length errors are caught in the regfile
   assign o_busy      = busy;
   assign o_done      = done_q;

endmodule

/* rtl/hdr_regfile.sv */
module hdr_regfile #(
   parameter int BUF_DEPTH = 8
) (
   input  logic                          i_sys_clk,
   input  logic                          i_rst,
   input  logic                          i_wb_cyc,
   input  logic                          i_wb_stb,
   input  logic                          i_wb_we,
   input  logic [hdr_pkg::REG_ADR_W-1:0] i_wb_adr,
   input  logic [hdr_pkg::WORD_W-1:0]    i_wb_dat,
   output logic [hdr_pkg::WORD_W-1:0]    o_wb_dat,
   output logic                          o_wb_ack,
   hdr_cfg_if.regf                       cfg
);
   import hdr_pkg::*;

   localparam int BI_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam logic [REG_ADR_W-1:0] DEPTH_A = REG_ADR_W'(BUF_DEPTH);
   localparam logic [IDX_W-1:0]     DEPTH_L = IDX_W'(BUF_DEPTH);

   logic [WORD_W-1:0]    cmd_q;
   logic [IDX_W-1:0]     len_q;
   logic                 start_q;
   logic                 done_q;
   logic                 lerr_q;
   logic [WORD_W-1:0]    buf_mem [BUF_DEPTH];
   logic                 req;
   logic [REG_ADR_W-1:0] buf_off;
   logic                 in_buf;
   logic                 len_ok;
   logic [WORD_W-1:0]    rd_data;

   // stb still high in the ack cycle is no new request
   assign req     = i_wb_cyc & i_wb_stb & ~o_wb_ack;
   assign buf_off = i_wb_adr - REG_BUF_BASE;
   assign in_buf  = (i_wb_adr >= REG_BUF_BASE) && (buf_off < DEPTH_A);
   assign len_ok  = (len_q != '0) && (len_q <= DEPTH_L);

   always_ff @(posedge i_sys_clk) begin
      if (i_rst) begin
         o_wb_ack <= 1'b0;
         start_q  <= 1'b0;
         done_q   <= 1'b0;
         lerr_q   <= 1'b0;
         cmd_q    <= '0;
         len_q    <= '0;
      end else begin
         o_wb_ack <= req;
         start_q  <= 1'b0;
         if (cfg.done)
            done_q <= 1'b1;
         if (req && i_wb_we) begin
            case (i_wb_adr)
               REG_CTRL: begin
                  if (i_wb_dat[0] && !cfg.busy) begin  // start while busy is dropped
                     done_q <= 1'b0;
                     if (len_ok) begin
                        start_q <= 1'b1;
                        lerr_q  <= 1'b0;
                     end else begin
                        lerr_q <= 1'b1;
                     end
                  end
               end
               REG_CMD: cmd_q <= i_wb_dat;
               REG_LEN: len_q <= i_wb_dat[IDX_W-1:0];
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge i_sys_clk) begin
      if (req && i_wb_we && in_buf)
         buf_mem[buf_off[BI_W-1:0]] <= i_wb_dat;
   end

   always_comb begin
      rd_data = '0;  // ctrl and holes read 0
      if (in_buf) begin
         rd_data = buf_mem[buf_off[BI_W-1:0]];
      end else begin
         case (i_wb_adr)
            REG_STATUS: rd_data = {{(WORD_W-3){1'b0}}, lerr_q, done_q, cfg.busy};
            REG_CMD:    rd_data = cmd_q;
            REG_LEN:    rd_data = {{(WORD_W-IDX_W){1'b0}}, len_q};
            default:    ;
         endcase
      end
   end

   // read data lines up with ack
   always_ff @(posedge i_sys_clk) begin
      if (req)
         o_wb_dat <= rd_data;
   end

   assign cfg.start    = start_q;
   assign cfg.cmd_word = cmd_q;
   assign cfg.len      = len_q;
   assign cfg.buf_word = buf_mem[cfg.buf_idx[BI_W-1:0]];

endmodule

/* rtl/hdr_tx_if.sv */
interface hdr_tx_if;
   import hdr_pkg::*;

   logic         valid;
   logic         ready;  // low while a frame is on the wire
   frame_kind_e  kind;
   ddr_payload_u word;   // don't care for FRAME_CRC

   modport seq (
      output valid,
      output kind,
      output word,
      input  ready
   );

   modport tx (
      input  valid,
      input  kind,
      input  word,
      output ready
   );

endinterface

/* rtl/hdr_cfg_if.sv */
interface hdr_cfg_if;
   import hdr_pkg::*;

   logic              start;     // one cycle, already validated
   logic [WORD_W-1:0] cmd_word;  // raw REG_CMD contents
   logic [IDX_W-1:0]  len;
   logic [WORD_W-1:0] buf_word;  // comb read at buf_idx
   logic [IDX_W-1:0]  buf_idx;
   logic              busy;
   logic              done;      // one cycle at end of transfer
   logic              err;

   modport regf (
      output start,
      output cmd_word,
      output len,
      output buf_word,
      input  buf_idx,
      input  busy,
      input  done,
      input  err
   );

   modport seq (
      input  start,
      input  cmd_word,
      input  len,
      input  buf_word,
      output buf_idx,
      output busy,
      output done,
      output err
   );

endinterface

/* rtl/hdr_pkg.sv */
package hdr_pkg;

   // widths
   localparam int WORD_W        = 16;
   localparam int BUF_DEPTH_MAX = 8;
   localparam int IDX_W         = $clog2(BUF_DEPTH_MAX + 1);  // holds 0..BUF_DEPTH_MAX
   localparam int REG_ADR_W     = 4;

   // wishbone register map, word addresses
   localparam logic [REG_ADR_W-1:0] REG_CTRL     = 4'd0;  // bit 0 start, write only
   localparam logic [REG_ADR_W-1:0] REG_STATUS   = 4'd1;  // busy, done, len error
   localparam logic [REG_ADR_W-1:0] REG_CMD      = 4'd2;  // code 14:8, addr 6:0
   localparam logic [REG_ADR_W-1:0] REG_LEN      = 4'd3;
   localparam logic [REG_ADR_W-1:0] REG_BUF_BASE = 4'd8;  // 8..15 data buffer

   typedef enum logic [1:0] {
      FRAME_CMD,
      FRAME_DATA,
      FRAME_CRC
   } frame_kind_e;

   // ddr preambles
   localparam logic [1:0] PRE_CMD  = 2'b01;
   localparam logic [1:0] PRE_DATA = 2'b10;
   localparam logic [1:0] PRE_CRC  = 2'b01;

   localparam logic [3:0] CRC_TOKEN = 4'hC;
   localparam logic [4:0] CRC_INIT  = 5'h1F;

   // command word as it goes on the wire
   typedef struct packed {
      logic       rnw;   // always write here
      logic [6:0] code;
      logic [6:0] addr;
      logic       pad;
   } ddr_cmd_t;

   // one 16 bit payload, seen as command fields or as a raw data word
   typedef union packed {
      ddr_cmd_t          cmd;
      logic [WORD_W-1:0] data;
   } ddr_payload_u;

endpackage
